// File: agu_replay.f
+incdir+design
+incdir+verification
design/agu_replay_pkg.sv
design/replay_row_if.sv
design/replay_row_ram.sv
design/replay_queue_ctrl.sv
design/replay_lane_picker.sv
design/agu_replay_top.sv
verification/agu_replay_tb.sv

// File: design/agu_replay_params.svh
// sizing macros for the address-unit replay queue
// depth, pointer width, lanes per row, skip level and payload widths

`ifndef AGU_REPLAY_PARAMS_SVH
`define AGU_REPLAY_PARAMS_SVH

// row entries in the circular buffer
`define AGU_REPLAY_DEPTH 8
`define AGU_REPLAY_PTR_W 3

// memory operations arriving together per cycle
`define AGU_LANES 3

// occupancy that raises skip
`define AGU_SKIP_LEVEL 4

// operation payload widths
`define AGU_VADDR_W 44
`define AGU_REG_W 9

`endif

// File: design/agu_replay_pkg.sv
// operation and row types for the replay queue
// one memory operation and one stored row of up to three operations

`default_nettype none

`include "agu_replay_params.svh"

package agu_replay_pkg;

  // one memory operation from the address unit
  typedef struct packed {
    logic [`AGU_VADDR_W-1:0] addr_main;
    logic [`AGU_REG_W-1:0]   reg_no;
    logic [1:0]              op_type;
    logic [4:0]              sz;
    logic                    invtlb;
    // access crosses a line boundary
    logic                    split;
    logic [4:0]              bank0;
    // load/store queue slot
    logic [8:0]              lsq;
    logic [9:0]              ii;
    logic [5:0]              wq;
    logic                    thread;
    logic                    lsflag;
    logic [3:0]              attr;
  } mem_op_t;

  // one row as held in storage
  // pending marks the lanes that had a conflict
  typedef struct packed {
    logic [`AGU_LANES-1:0]    pending;
    mem_op_t [`AGU_LANES-1:0] ops;
  } replay_row_t;

endpackage

`default_nettype wire

// File: design/agu_replay_top.sv
// top level of the address-unit replay queue
// row storage, queue control and lane picker tied together

`default_nettype none

`include "agu_replay_params.svh"

module agu_replay_top
  import agu_replay_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  mem_op_t               op0,
  input  mem_op_t               op1,
  input  mem_op_t               op2,
  input  logic [`AGU_LANES-1:0] conflict,
  input  logic                  read_clk_en,
  input  logic                  rs_stall,
  input  logic                  except,
  output logic                  out_en,
  output mem_op_t               out_op,
  output logic                  skip
);

  replay_row_t serve_row;
  logic        row_live;
  logic        row_done;

  // control to storage
  replay_row_if row_bus ();

  replay_row_ram u_ram (
    .clk (clk),
    .rst (rst),
    .row (row_bus.ram)
  );

  replay_queue_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .op0       (op0),
    .op1       (op1),
    .op2       (op2),
    .conflict  (conflict),
    .rs_stall  (rs_stall),
    .except    (except),
    .row_done  (row_done),
    .row       (row_bus.ctrl),
    .serve_row (serve_row),
    .row_live  (row_live),
    .skip      (skip)
  );

  replay_lane_picker u_picker (
    .clk         (clk),
    .rst         (rst),
    .serve_row   (serve_row),
    .row_live    (row_live),
    .read_clk_en (read_clk_en),
    .rs_stall    (rs_stall),
    .except      (except),
    .out_en      (out_en),
    .out_op      (out_op),
    .row_done    (row_done)
  );

endmodule

`default_nettype wire

// File: design/replay_lane_picker.sv
// lane picker for the replay queue
// masks lanes already sent, selects the lowest pending lane,
// drives the replay output and signals the end of a row

`default_nettype none

`include "agu_replay_params.svh"

module replay_lane_picker
  import agu_replay_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  replay_row_t serve_row,
  input  logic        row_live,
  input  logic        read_clk_en,
  input  logic        rs_stall,
  input  logic        except,
  output logic        out_en,
  output mem_op_t     out_op,
  output logic        row_done
);

  logic [`AGU_LANES-1:0] sent;
  logic [`AGU_LANES-1:0] remain;
  logic [`AGU_LANES-1:0] sel;
  logic                  fire;

  assign remain = serve_row.pending & ~sent;

  // isolate the lowest set bit
  assign sel = remain & (~remain + 1'b1);

  assign fire = row_live & read_clk_en & ~rs_stall & ~except & (|remain);

  // nothing left once the selected lane goes
  assign row_done = fire & ~(|(remain & ~sel));
  assign out_en   = fire;

  // one-hot select of the outgoing operation
  always_comb begin
    out_op = '0;
    for (int i = 0; i < `AGU_LANES; i++) begin
      if (sel[i]) begin
        out_op = serve_row.ops[i];
      end
    end
  end

  // sent mask follows the served row across the bypass-to-storage handover
  always_ff @(posedge clk) begin
    if (rst || except) begin
      sent <= '0;
    end else if (row_done) begin
      sent <= '0;
    end else if (fire) begin
      sent <= sent | sel;
    end
  end

endmodule

`default_nettype wire

// File: design/replay_queue_ctrl.sv
// replay queue control
// capture register, write/read pointers, valid bits and occupancy
// bypass of the captured row, flush on exception, skip hysteresis

`default_nettype none

`include "agu_replay_params.svh"

module replay_queue_ctrl
  import agu_replay_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  mem_op_t               op0,
  input  mem_op_t               op1,
  input  mem_op_t               op2,
  input  logic [`AGU_LANES-1:0] conflict,
  input  logic                  rs_stall,
  input  logic                  except,
  input  logic                  row_done,
  replay_row_if.ctrl            row,
  output replay_row_t           serve_row,
  output logic                  row_live,
  output logic                  skip
);

  replay_row_t                  cap_row;
  logic                         cap_vld;
  logic                         cap_take;
  logic [`AGU_REPLAY_PTR_W-1:0] wr_ptr;
  logic [`AGU_REPLAY_PTR_W-1:0] rd_ptr;
  logic [`AGU_REPLAY_PTR_W-1:0] rd_ptr_next;
  logic [`AGU_REPLAY_DEPTH-1:0] valid;
  logic [`AGU_REPLAY_PTR_W:0]   occ;
  logic                         any_valid;
  logic                         bypass;
  logic                         wr_go;
  logic                         keep_row;
  logic                         pop;

  // new row only when some lane conflicts and the unit can move
  assign cap_take = (|conflict) & ~except & ~rs_stall & ~row.clearing;

  // rows sit contiguously from rd_ptr, so any valid bit means the head is valid
  assign any_valid = |valid;
  assign bypass    = cap_vld & ~any_valid;

  // write the captured row one cycle after capture
  assign wr_go = cap_vld & ~rs_stall & ~except & ~row.clearing;

  // a bypassed row that finishes in its write cycle is never marked valid
  assign keep_row = wr_go & ~(bypass & row_done);
  assign pop      = row_done & any_valid;

  // head advances on every finished row, stored or bypassed
  always_comb begin
    if (except) begin
      rd_ptr_next = wr_ptr;
    end else if (row_done) begin
      rd_ptr_next = rd_ptr + 1'b1;
    end else begin
      rd_ptr_next = rd_ptr;
    end
  end

  // oldest stored row first, else the fresh capture
  assign serve_row = any_valid ? row.rd_row : cap_row;
  assign row_live  = any_valid | cap_vld;

  assign row.wr_en        = wr_go;
  assign row.wr_addr      = wr_ptr;
  assign row.wr_row       = cap_row;
  assign row.rd_addr_next = rd_ptr_next;

  // capture payload
  always_ff @(posedge clk) begin
    if (cap_take) begin
      cap_row.pending <= conflict;
      cap_row.ops     <= {op2, op1, op0};
    end
  end

  // pointers, valid vector and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_vld <= 1'b0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      valid   <= '0;
      occ     <= '0;
    end else if (except) begin
      // flush everything, including a row still in the capture stage
      cap_vld <= 1'b0;
      valid   <= '0;
      occ     <= '0;
      rd_ptr  <= wr_ptr;
    end else if (!rs_stall) begin
      cap_vld <= cap_take;
      rd_ptr  <= rd_ptr_next;
      if (wr_go) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        valid[rd_ptr] <= 1'b0;
      end
      if (keep_row) begin
        valid[wr_ptr] <= 1'b1;
      end
      occ <= occ + {{`AGU_REPLAY_PTR_W{1'b0}}, keep_row}
                 - {{`AGU_REPLAY_PTR_W{1'b0}}, pop};
    end
  end

  // skip rises at the high mark and holds until the queue drains
  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
    end else if (occ >= `AGU_SKIP_LEVEL) begin
      skip <= 1'b1;
    end else if (occ == '0) begin
      skip <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/replay_row_if.sv
// row bus between the queue control and the row storage
// write port, next read address, read data and sweep status

`default_nettype none

`include "agu_replay_params.svh"

interface replay_row_if
  import agu_replay_pkg::*;
();

  logic                         wr_en;
  logic [`AGU_REPLAY_PTR_W-1:0] wr_addr;
  replay_row_t                  wr_row;
  // address the storage latches at the coming edge
  logic [`AGU_REPLAY_PTR_W-1:0] rd_addr_next;
  replay_row_t                  rd_row;
  // high while storage is being wiped after reset
  logic                         clearing;

  modport ctrl (output wr_en, wr_addr, wr_row, rd_addr_next, input rd_row, clearing);

  modport ram (input wr_en, wr_addr, wr_row, rd_addr_next, output rd_row, clearing);

endinterface

`default_nettype wire

// File: design/replay_row_ram.sv
// row storage for the replay queue
// registered read address, write-first reads, post-reset clearing sweep

`default_nettype none

`include "agu_replay_params.svh"

module replay_row_ram
  import agu_replay_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  replay_row_if.ram  row
);

  replay_row_t                  mem [`AGU_REPLAY_DEPTH];
  logic [`AGU_REPLAY_PTR_W-1:0] rd_addr;
  logic [`AGU_REPLAY_PTR_W-1:0] clr_cnt;
  logic                         clearing;

  assign row.clearing = clearing;

  // address is registered, data is read straight from the array
  // so a write at the same edge is seen on the following cycle
  assign row.rd_row = mem[rd_addr];

  // sweep counter and read address
  always_ff @(posedge clk) begin
    if (rst) begin
      clearing <= 1'b1;
      clr_cnt  <= '0;
      rd_addr  <= '0;
    end else if (clearing) begin
      clr_cnt <= clr_cnt + 1'b1;
      // last entry reached, depth is a power of two
      if (&clr_cnt) begin
        clearing <= 1'b0;
      end
    end else begin
      rd_addr <= row.rd_addr_next;
    end
  end

  // array writes, the sweep owns the port until it finishes
  always_ff @(posedge clk) begin
    if (clearing && !rst) begin
      mem[clr_cnt] <= '0;
    end else if (row.wr_en && !clearing) begin
      mem[row.wr_addr] <= row.wr_row;
    end
  end

endmodule

`default_nettype wire

// File: verification/agu_replay_model.svh
// reference model for the replay queue testbench
// expected operation queue, row push, flush and output compare

`ifndef AGU_REPLAY_MODEL_SVH
`define AGU_REPLAY_MODEL_SVH

// operations the DUT still owes, oldest first
mem_op_t exp_q[$];

// flagged lanes replay lowest lane first
task automatic push_row(input mem_op_t o0, input mem_op_t o1, input mem_op_t o2,
                        input logic [`AGU_LANES-1:0] mask);
  if (mask[0]) begin
    exp_q.push_back(o0);
  end
  if (mask[1]) begin
    exp_q.push_back(o1);
  end
  if (mask[2]) begin
    exp_q.push_back(o2);
  end
endtask

// exception flushes every stored row
task automatic drop_all();
  exp_q.delete();
endtask

task automatic check_output(input mem_op_t got);
  mem_op_t want;
  if (exp_q.size() == 0) begin
    $display("error at %0t: replay of lsq %0d with no operation outstanding", $time, got.lsq);
    other_errs++;
  end else begin
    want = exp_q.pop_front();
    checked_ops++;
    // all fields compared, lsq shown as the tag
    if (got !== want) begin
      $display("MISMATCH at %0t: expected lsq %0d, got lsq %0d", $time, want.lsq, got.lsq);
      mismatch_errs++;
    end
  end
endtask

`endif

// File: verification/agu_replay_tb.sv
// testbench for the address-unit replay queue
// LFSR stimulus, directed bypass and skip runs, model checks and report

`default_nettype none

`include "agu_replay_params.svh"

module agu_replay_tb
  import agu_replay_pkg::*;
();

  localparam int RAND_CYCLES     = 2000;
  localparam int BYPASS_RUNS     = 4;
  // reset, sweep and lead-in plus a drain budget per directed run
  localparam int DIRECTED_CYCLES = 26 + (BYPASS_RUNS + 2) * 40;
  localparam int TIMEOUT_CYCLES  = 4 * (RAND_CYCLES + DIRECTED_CYCLES) + 200;

  logic                  clk = 1'b0;
  logic                  rst;
  mem_op_t               op0;
  mem_op_t               op1;
  mem_op_t               op2;
  logic [`AGU_LANES-1:0] conflict;
  logic                  read_clk_en;
  logic                  rs_stall;
  logic                  except;
  logic                  out_en;
  mem_op_t               out_op;
  logic                  skip;

  logic [15:0] lfsr_state;
  logic [8:0]  serial;
  logic        skip_seen;
  logic        quiet;
  int          cycle_cnt;
  int          mismatch_errs;
  int          other_errs;
  int          checked_ops;

  `include "agu_replay_model.svh"

  agu_replay_top u_agu_replay_top (
    .clk         (clk),
    .rst         (rst),
    .op0         (op0),
    .op1         (op1),
    .op2         (op2),
    .conflict    (conflict),
    .read_clk_en (read_clk_en),
    .rs_stall    (rs_stall),
    .except      (except),
    .out_en      (out_en),
    .out_op      (out_op),
    .skip        (skip)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step for every bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [`AGU_LANES-1:0] nonzero_mask();
    logic [63:0] v;
    v = take_bits(`AGU_LANES);
    return (v[`AGU_LANES-1:0] == '0) ? `AGU_LANES'(1) : v[`AGU_LANES-1:0];
  endfunction

  // random payload, lsq carries a running serial number
  task automatic build_op(output mem_op_t op);
    logic [127:0] raw;
    raw = '0;
    raw[63:0]   = take_bits(64);
    raw[127:64] = take_bits($bits(mem_op_t) - 64);
    op          = raw[$bits(mem_op_t)-1:0];
    op.lsq      = serial;
    serial      = serial + 1'b1;
  endtask

  task automatic present_row(input logic [`AGU_LANES-1:0] mask, output mem_op_t lowest);
    mem_op_t a;
    mem_op_t b;
    mem_op_t c;
    build_op(a);
    build_op(b);
    build_op(c);
    op0      <= a;
    op1      <= b;
    op2      <= c;
    conflict <= mask;
    lowest = mask[0] ? a : (mask[1] ? b : c);
  endtask

  task automatic drive_random_cycle();
    mem_op_t     unused;
    logic [63:0] v;
    v = take_bits(`AGU_LANES + 1);
    // source holds off while skip is up
    if (!skip_seen && v[`AGU_LANES]) begin
      present_row(v[`AGU_LANES-1:0], unused);
    end else begin
      conflict <= '0;
    end
    rs_stall    <= (take_bits(3) == 0);
    except      <= (take_bits(5) == 0);
    read_clk_en <= (take_bits(2) != 0);
  endtask

  task automatic drain_queue();
    @(posedge clk);
    conflict    <= '0;
    rs_stall    <= 1'b0;
    except      <= 1'b0;
    read_clk_en <= 1'b1;
    while (exp_q.size() != 0 || skip_seen) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  // empty queue, lowest flagged lane out one cycle after presentation
  task automatic check_bypass();
    mem_op_t want;
    drain_queue();
    present_row(nonzero_mask(), want);
    @(posedge clk);
    conflict <= '0;
    @(negedge clk);
    if (out_en !== 1'b1) begin
      $display("error at %0t: bypassed row not replayed one cycle after it was presented",
               $time);
      other_errs++;
    end else if (out_op.lsq !== want.lsq) begin
      $display("MISMATCH at %0t: bypass expected lsq %0d, got lsq %0d", $time, want.lsq,
               out_op.lsq);
      mismatch_errs++;
    end
  endtask

  task automatic check_skip();
    mem_op_t unused;
    drain_queue();
    read_clk_en <= 1'b0;
    repeat (4) begin
      @(posedge clk);
      present_row(nonzero_mask(), unused);
    end
    @(posedge clk);
    conflict <= '0;
    @(posedge clk);
    @(negedge clk);
    if (skip !== 1'b0) begin
      $display("error at %0t: skip rose before the fourth row was stored", $time);
      other_errs++;
    end
    @(negedge clk);
    if (skip !== 1'b1) begin
      $display("error at %0t: skip not high two cycles after the fourth row", $time);
      other_errs++;
    end
    @(posedge clk);
    read_clk_en <= 1'b1;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(negedge clk);
    if (skip !== 1'b0) begin
      $display("error at %0t: skip still high after the queue drained", $time);
      other_errs++;
    end
  endtask

  // per-cycle output checks and model update, mid-cycle where all is settled
  always @(negedge clk) begin
    skip_seen = skip;
    if (quiet) begin
      if (out_en !== 1'b0 || skip !== 1'b0) begin
        $display("error at %0t: output active during reset or the clearing sweep", $time);
        other_errs++;
      end
    end else begin
      if (out_en === 1'b1) begin
        if (rs_stall || except) begin
          $display("error at %0t: replay output during a stall or exception cycle", $time);
          other_errs++;
        end
        check_output(out_op);
      end else if (out_en !== 1'b0) begin
        $display("error at %0t: out_en is unknown", $time);
        other_errs++;
      end
      if (except) begin
        drop_all();
      end else if (!rs_stall && conflict != '0) begin
        push_row(op0, op1, op2, conflict);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display("errors: %0d mismatches, %0d other failures, %0d operations checked",
               mismatch_errs, other_errs, checked_ops);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    mem_op_t unused;
    rst           = 1'b1;
    op0           = '0;
    op1           = '0;
    op2           = '0;
    conflict      = '0;
    // replay enabled from the start so a leak during the sweep shows up
    read_clk_en   = 1'b1;
    rs_stall      = 1'b0;
    except        = 1'b0;
    lfsr_state    = 16'd15871;
    serial        = '0;
    skip_seen     = 1'b0;
    quiet         = 1'b1;
    cycle_cnt     = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    checked_ops   = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // rows offered during the sweep must be dropped
    repeat (8) begin
      present_row('1, unused);
      @(posedge clk);
    end
    quiet = 1'b0;
    conflict    <= '0;
    read_clk_en <= 1'b1;
    repeat (10) @(posedge clk);
    repeat (BYPASS_RUNS) check_bypass();
    check_skip();
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge clk);
      drive_random_cycle();
    end
    drain_queue();
    if (exp_q.size() != 0) begin
      $display("error: %0d operations never replayed", exp_q.size());
      other_errs++;
    end
    if (checked_ops == 0) begin
      $display("error: no operation was replayed");
      other_errs++;
    end
    $display("errors: %0d mismatches, %0d other failures, %0d operations checked",
             mismatch_errs, other_errs, checked_ops);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
